// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_stream_framer \
    --Mdir obj_dir -o sim_stream_framer
./obj_dir/sim_stream_framer > "$LOG"
cat "$LOG"

if grep -qx "all tests passed" "$LOG"; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// File: source/frame_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module frame_assembler (
    input  wire                         CLK,
    input  wire                         RST_N,
    input  wire stream_pkg::beat_u      beat,
    input  wire                         beat_vld,
    input  wire                         beat_last,
    output logic                        beat_rdy,
    input  wire stream_pkg::frame_sum_t sum,
    input  wire                         sum_vld,
    output logic                        sum_rdy,
    output stream_pkg::beat_u           out_beat,
    output logic                        out_vld,
    output logic                        out_last,
    input  wire                         out_rdy
);
    import stream_pkg::*;

    typedef enum logic {
        ST_DATA,
        ST_TRAILER
    } state_t;

    state_t      state_q;
    logic [15:0] beat_cnt_q;
    trailer_t    trl;
    logic        data_fire;
    logic        trl_fire;

    assign trl.sum        = sum.sum;
    assign trl.word_count = sum.word_count;
    assign trl.beat_count = beat_cnt_q;

    // Data passes straight through while the trailer waits on the checksum.
    always_comb begin
        out_beat = beat;
        out_vld  = beat_vld;
        out_last = 1'b0;
        beat_rdy = out_rdy;
        sum_rdy  = 1'b0;
        if (state_q == ST_TRAILER) begin
            out_beat.trailer = trl;
            out_vld          = sum_vld;
            out_last         = 1'b1;
            beat_rdy         = 1'b0; // Next frame holds back.
            sum_rdy          = out_rdy;
        end
    end

    assign data_fire = (state_q == ST_DATA) & beat_vld & out_rdy;
    assign trl_fire  = (state_q == ST_TRAILER) & sum_vld & out_rdy;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state_q    <= ST_DATA;
            beat_cnt_q <= '0;
        end else if (data_fire) begin
            beat_cnt_q <= beat_cnt_q + 16'd1;
            if (beat_last) begin
                state_q <= ST_TRAILER;
            end
        end else if (trl_fire) begin
            // Checksum entry pops on this same edge.
            state_q    <= ST_DATA;
            beat_cnt_q <= '0;
        end
    end

endmodule

`default_nettype wire

// File: source/frame_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module frame_checksum (
    input  wire                       CLK,
    input  wire                       RST_N,
    input  wire stream_pkg::in_word_t word_acc,
    input  wire                       word_acc_vld,
    output stream_pkg::frame_sum_t    sum,
    output logic                      sum_vld,
    input  wire                       sum_rdy
);
    import stream_pkg::*;

    logic [31:0] run_sum_q;
    logic [15:0] run_cnt_q;
    frame_sum_t  next_res;      // Totals including the current word.
    frame_sum_t  res_q [2];     // Entry 0 is the oldest.
    logic [1:0]  fill_q;
    logic [1:0]  wr_pos;
    logic        push;
    logic        pop;

    assign next_res.sum        = run_sum_q + 32'(word_acc.dat);
    assign next_res.word_count = run_cnt_q + 16'd1;

    assign push = word_acc_vld & word_acc.last;
    assign pop  = sum_vld & sum_rdy;

    // Slot for a new result after any pop has shifted the queue.
    assign wr_pos = fill_q - {1'b0, pop};

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            run_sum_q <= '0;
            run_cnt_q <= '0;
        end else if (word_acc_vld) begin
            if (word_acc.last) begin
                run_sum_q <= '0; // Next frame starts clean.
                run_cnt_q <= '0;
            end else begin
                run_sum_q <= next_res.sum;
                run_cnt_q <= next_res.word_count;
            end
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            fill_q <= '0;
        end else begin
            fill_q <= fill_q + {1'b0, push} - {1'b0, pop};
        end
    end

    // Two slots are enough since the packer holds one beat at most.
    always_ff @(posedge CLK) begin
        if (pop) begin
            res_q[0] <= res_q[1];
        end
        if (push) begin
            res_q[wr_pos[0]] <= next_res;
        end
    end

    assign sum     = res_q[0];
    assign sum_vld = (fill_q != 2'd0);

endmodule

`default_nettype wire

// File: source/stream_consts.svh
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Input word width.
`define STREAM_IN_W 16

// Output beat width.
`define STREAM_OUT_W 64

// Words gathered into one beat.
`define STREAM_WORDS_PER_BEAT (`STREAM_OUT_W / `STREAM_IN_W)

`endif

// File: source/stream_framer_top.sv
`timescale 1ns/1ps
`default_nettype none

module stream_framer_top (
    input  wire                       CLK,
    input  wire                       RST_N,
    input  wire stream_pkg::in_word_t in_word,
    input  wire                       in_vld,
    output logic                      in_rdy,
    output stream_pkg::beat_u         out_beat,
    output logic                      out_vld,
    output logic                      out_last,
    input  wire                       out_rdy
);
    import stream_pkg::*;

    in_word_t   word_acc;      // Packer to checksum.
    logic       word_acc_vld;
    beat_u      beat;          // Packer to assembler.
    logic       beat_vld;
    logic       beat_last;
    logic       beat_rdy;
    frame_sum_t sum;           // Checksum to assembler.
    logic       sum_vld;
    logic       sum_rdy;

    word_packer u_packer (
        .CLK          (CLK),
        .RST_N        (RST_N),
        .in_word      (in_word),
        .in_vld       (in_vld),
        .in_rdy       (in_rdy),
        .word_acc     (word_acc),
        .word_acc_vld (word_acc_vld),
        .beat         (beat),
        .beat_vld     (beat_vld),
        .beat_last    (beat_last),
        .beat_rdy     (beat_rdy)
    );

    frame_checksum u_checksum (
        .CLK          (CLK),
        .RST_N        (RST_N),
        .word_acc     (word_acc),
        .word_acc_vld (word_acc_vld),
        .sum          (sum),
        .sum_vld      (sum_vld),
        .sum_rdy      (sum_rdy)
    );

    frame_assembler u_assembler (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .beat      (beat),
        .beat_vld  (beat_vld),
        .beat_last (beat_last),
        .beat_rdy  (beat_rdy),
        .sum       (sum),
        .sum_vld   (sum_vld),
        .sum_rdy   (sum_rdy),
        .out_beat  (out_beat),
        .out_vld   (out_vld),
        .out_last  (out_last),
        .out_rdy   (out_rdy)
    );

endmodule

`default_nettype wire

// File: source/stream_pkg.sv
`default_nettype none
`include "stream_consts.svh"

package stream_pkg;

    // One input word with its end of frame flag.
    typedef struct packed {
        logic                    last;
        logic [`STREAM_IN_W-1:0] dat;
    } in_word_t;

    // Per frame result from the checksum unit.
    typedef struct packed {
        logic [31:0] sum;        // Modulo 2^32.
        logic [15:0] word_count;
    } frame_sum_t;

    // Trailer layout with the sum in the top half.
    typedef struct packed {
        logic [31:0] sum;
        logic [15:0] word_count;
        logic [15:0] beat_count; // Data beats in the frame.
    } trailer_t;

    // An output beat is either packed data or a trailer.
    typedef union packed {
        logic [`STREAM_OUT_W-1:0] data; // Word 0 in the low lane.
        trailer_t                 trailer;
    } beat_u;

endpackage

`default_nettype wire

// File: source/word_packer.sv
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module word_packer (
    input  wire                       CLK,
    input  wire                       RST_N,
    input  wire stream_pkg::in_word_t in_word,
    input  wire                       in_vld,
    output logic                      in_rdy,
    output stream_pkg::in_word_t      word_acc,
    output logic                      word_acc_vld,
    output stream_pkg::beat_u         beat,
    output logic                      beat_vld,
    output logic                      beat_last,
    input  wire                       beat_rdy
);
    import stream_pkg::*;

    localparam int LANE_W = $clog2(`STREAM_WORDS_PER_BEAT);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`STREAM_WORDS_PER_BEAT - 1);

    logic [LANE_W-1:0] lane_q;  // Next lane to fill.
    logic              vld_q;
    logic              last_q;
    beat_u             shift_q;
    beat_u             shift_d;
    logic              in_fire;
    logic              out_fire;
    logic              beat_done;

    // Take a word while empty or while the held beat leaves.
    assign in_rdy    = !vld_q | beat_rdy;
    assign in_fire   = in_vld & in_rdy;
    assign out_fire  = vld_q & beat_rdy;
    assign beat_done = in_fire & (in_word.last | (lane_q == LAST_LANE));

    // A fresh beat starts from zero so short beats come out zero filled.
    always_comb begin
        shift_d = shift_q;
        if (lane_q == '0) begin
            shift_d.data = '0;
        end
        shift_d.data[lane_q * `STREAM_IN_W +: `STREAM_IN_W] = in_word.dat;
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            lane_q <= '0;
            vld_q  <= 1'b0;
            last_q <= 1'b0;
        end else begin
            if (out_fire) begin
                vld_q  <= 1'b0;
                last_q <= 1'b0;
            end
            if (in_fire) begin
                if (beat_done) begin
                    lane_q <= '0;
                    vld_q  <= 1'b1; // Overrides the clear above.
                    last_q <= in_word.last;
                end else begin
                    lane_q <= lane_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (in_fire) begin
            shift_q <= shift_d;
        end
    end

    // Checksum unit sees every accepted word on the same edge.
    assign word_acc     = in_word;
    assign word_acc_vld = in_fire;

    assign beat      = shift_q;
    assign beat_vld  = vld_q;
    assign beat_last = last_q;

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/stream_pkg.sv
source/word_packer.sv
source/frame_checksum.sv
source/frame_assembler.sv
source/stream_framer_top.sv
verification/tb_stream_framer.sv

// File: verification/tb_stream_framer.sv
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module tb_stream_framer;
    import stream_pkg::*;

    localparam int NUM_TESTS = 12;
    localparam int TIMEOUT   = 200;   // Cycles per wait.

    logic     CLK;
    logic     RST_N;
    in_word_t in_word;
    logic     in_vld;
    logic     in_rdy;
    beat_u    out_beat;
    logic     out_vld;
    logic     out_last;
    logic     out_rdy;

    string       tbl_name [NUM_TESTS];
    int          tbl_len  [NUM_TESTS];
    logic [15:0] tbl_src  [NUM_TESTS];  // Source stall pattern.
    logic [15:0] tbl_sink [NUM_TESTS];  // Sink stall pattern.

    logic [63:0] exp_beat_q [$];
    logic        exp_last_q [$];
    int          exp_row_q  [$];
    logic [15:0] frame_words [$];
    logic [31:0] lfsr_q;
    int          cyc_cnt;
    logic        hung;
    logic        drv_done;
    int          value_errs;
    int          stable_errs;
    int          other_errs;
    int          timeouts;

    stream_framer_top uut (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .in_word  (in_word),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .out_beat (out_beat),
        .out_vld  (out_vld),
        .out_last (out_last),
        .out_rdy  (out_rdy)
    );

    always #2 CLK = ~CLK;

    always @(posedge CLK) cyc_cnt <= cyc_cnt + 1;  // Indexes the stall masks.

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    // One LFSR step per data bit.
    task automatic next_word(output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < `STREAM_IN_W; i++) begin
            v = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic set_row(input int r, input string name, input int len,
                           input logic [15:0] src, input logic [15:0] sink);
        tbl_name[r] = name;
        tbl_len[r]  = len;
        tbl_src[r]  = src;
        tbl_sink[r] = sink;
    endtask

    task automatic flag_timeout(input string what);
        if (!hung) begin
            $display("timeout: %s", what);
            timeouts++;
        end
        hung = 1'b1;
    endtask

    task automatic push_exp(input logic [63:0] b, input logic l, input int row);
        exp_beat_q.push_back(b);
        exp_last_q.push_back(l);
        exp_row_q.push_back(row);
    endtask

    // Reference model. Lane 0 first, zero fill, then one trailer.
    task automatic model_frame(input int row);
        logic [15:0] w;
        logic [63:0] acc;
        logic [31:0] sum;
        trailer_t    trl;
        int          lane;
        int          nbeats;
        int          i;
        frame_words.delete();
        acc    = '0;
        sum    = '0;
        lane   = 0;
        nbeats = 0;
        for (i = 0; i < tbl_len[row]; i++) begin
            next_word(w);
            frame_words.push_back(w);
            sum = sum + {16'h0000, w};
            acc[lane * `STREAM_IN_W +: `STREAM_IN_W] = w;
            lane++;
            if (lane == `STREAM_WORDS_PER_BEAT || i == tbl_len[row] - 1) begin
                push_exp(acc, 1'b0, row);
                acc  = '0;
                lane = 0;
                nbeats++;
            end
        end
        trl.sum        = sum;
        trl.word_count = 16'(tbl_len[row]);
        trl.beat_count = 16'(nbeats);
        push_exp(trl, 1'b1, row);
    endtask

    // Entered and left just after a rising edge.
    task automatic send_word(input int row, input logic [15:0] d, input logic l);
        int waited;
        waited = 0;
        while (!hung && tbl_src[row][cyc_cnt[3:0]]) begin
            in_vld = 1'b0;
            waited++;
            if (waited > TIMEOUT) flag_timeout("source stall never ended");
            @(posedge CLK);
            #1;
        end
        in_word.dat  = d;
        in_word.last = l;
        in_vld       = 1'b1;
        waited       = 0;
        @(negedge CLK);
        while (!hung && !in_rdy) begin
            waited++;
            if (waited > TIMEOUT) flag_timeout("input word was never accepted");
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic drive_frames();
        int r;
        int i;
        for (r = 0; r < NUM_TESTS && !hung; r++) begin
            model_frame(r);
            for (i = 0; i < frame_words.size() && !hung; i++) begin
                send_word(r, frame_words[i], i == frame_words.size() - 1);
            end
        end
        in_vld   = 1'b0;
        drv_done = 1'b1;
    endtask

    task automatic watch_outputs();
        int          idle;
        int          row;
        logic        held_vld;
        beat_u       held_beat;
        logic        held_last;
        logic [63:0] exp_beat;
        logic        exp_last;
        idle      = 0;
        held_vld  = 1'b0;
        held_beat = '0;
        held_last = 1'b0;
        while (!hung && (!drv_done || exp_beat_q.size() != 0)) begin
            row     = (exp_row_q.size() != 0) ? exp_row_q[0] : 0;
            out_rdy = !tbl_sink[row][cyc_cnt[3:0]];
            @(negedge CLK);
            if (held_vld) begin
                assert (out_vld && out_beat == held_beat && out_last == held_last) else begin
                    stable_errs++;
                    $display("beat changed or vanished while stalled in test %s", tbl_name[row]);
                end
            end
            held_vld  = out_vld && !out_rdy;
            held_beat = out_beat;
            held_last = out_last;
            if (out_vld && out_rdy) begin
                idle = 0;
                assert (exp_beat_q.size() != 0) else begin
                    other_errs++;
                    $display("output beat %h arrived with none expected", out_beat.data);
                end
                if (exp_beat_q.size() != 0) begin
                    exp_beat = exp_beat_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    void'(exp_row_q.pop_front());
                    assert (out_beat.data == exp_beat && out_last == exp_last) else begin
                        value_errs++;
                        $display("FAIL %s expected %h last %b actual %h last %b", tbl_name[row],
                                 exp_beat, exp_last, out_beat.data, out_last);
                    end
                end
            end else begin
                idle++;
                if (idle > TIMEOUT) flag_timeout("no output beat arrived in time");
            end
            @(posedge CLK);
            #1;
        end
        out_rdy = 1'b0;
    endtask

    initial begin
        CLK         = 1'b0;
        RST_N       = 1'b0;
        in_word     = '0;
        in_vld      = 1'b0;
        out_rdy     = 1'b0;
        lfsr_q      = 32'h6053;
        cyc_cnt     = 0;
        hung        = 1'b0;
        drv_done    = 1'b0;
        value_errs  = 0;
        stable_errs = 0;
        other_errs  = 0;
        timeouts    = 0;
        set_row(0,  "full_8",     8,  16'h0000, 16'h0000);
        set_row(1,  "short_1",    1,  16'h0000, 16'h0000);
        set_row(2,  "short_3",    3,  16'h0000, 16'h0000);
        set_row(3,  "short_5",    5,  16'h0000, 16'h0000);
        set_row(4,  "short_7",    7,  16'h0000, 16'h0000);
        set_row(5,  "sink_stall", 13, 16'h0000, 16'hb26d);
        set_row(6,  "src_stall",  6,  16'h5a31, 16'h0000);
        set_row(7,  "mixed",      11, 16'h2492, 16'hc3a5);
        set_row(8,  "b2b_pend",   5,  16'h0000, 16'hf0f0);  // Trailer waits here.
        set_row(9,  "b2b_one",    1,  16'h0000, 16'h0ff0);
        set_row(10, "stream_9",   9,  16'h0000, 16'h0000);
        set_row(11, "stream_4",   4,  16'h0000, 16'h0000);

        repeat (2) @(posedge CLK);
        #1;
        RST_N = 1'b1;
        @(negedge CLK);
        assert (!out_vld && !out_last && in_rdy) else begin
            value_errs++;
            $display("FAIL reset expected vld 0 last 0 rdy 1 actual vld %b last %b rdy %b",
                     out_vld, out_last, in_rdy);
        end
        @(posedge CLK);
        #1;

        fork
            drive_frames();
            watch_outputs();
        join

        // Nothing may follow the final trailer.
        if (!hung) begin
            repeat (4) begin
                @(negedge CLK);
                assert (!out_vld) else begin
                    other_errs++;
                    $display("extra output beat after the last frame");
                end
            end
        end

        $display("errors: %0d value, %0d stability, %0d protocol, %0d timeout",
                 value_errs, stable_errs, other_errs, timeouts);
        if (value_errs + stable_errs + other_errs + timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
